//--- flist.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/line_access.sv
hdl/data_cache.sv
hdl/line_memory.sv
hdl/cache_subsystem.sv
tests/tb_cache_subsystem.sv

//--- run.sh
#!/bin/sh
# Build and run the cache subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_cache_subsystem -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_cache_subsystem)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

//--- tests/tb_cache_subsystem.sv
`timescale 1ns/1ps

module tb_cache_subsystem import cache_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 10;
    localparam int ROW_CYCLES   = 40;  // Budget per table row

    typedef enum logic [1:0] {OP_LOAD, OP_STORE, OP_FLUSH} op_t;

    typedef struct {
        op_t   op;
        addr_t addr;
        size_t size;
        word_t wdata;
        strb_t wstrb;
        word_t exp_rdata;
        logic  exp_hit;
    } row_t;

    logic  clk;
    logic  rstn;
    logic  cpu_req;
    logic  cpu_wr;
    addr_t cpu_addr;
    word_t cpu_wdata;
    strb_t cpu_wstrb;
    size_t cpu_size;
    logic  cpu_ready;
    word_t cpu_rdata;
    logic  cpu_rvalid;
    logic  hit;
    logic  finish;
    logic  done;

    row_t rows[$];
    int   errors = 0;
    int   checks = 0;
    logic table_ready = 1'b0;

    cache_subsystem cache_subsystem_i (
        .clk        (clk),
        .rstn       (rstn),
        .cpu_req    (cpu_req),
        .cpu_wr     (cpu_wr),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_wstrb  (cpu_wstrb),
        .cpu_size   (cpu_size),
        .cpu_ready  (cpu_ready),
        .cpu_rdata  (cpu_rdata),
        .cpu_rvalid (cpu_rvalid),
        .hit        (hit),
        .finish     (finish),
        .done       (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic add_row(input op_t op, input addr_t addr, input size_t size,
                           input word_t wdata, input strb_t wstrb,
                           input word_t exp_rdata, input logic exp_hit);
        row_t row;
        row.op        = op;
        row.addr      = addr;
        row.size      = size;
        row.wdata     = wdata;
        row.wstrb     = wstrb;
        row.exp_rdata = exp_rdata;
        row.exp_hit   = exp_hit;
        rows.push_back(row);
    endtask

    // Memory word at byte address A holds A ^ 5A5A0000
    task automatic fill_table();
        add_row(OP_LOAD,  32'h3A4, SIZE_WORD, 32'h0, 4'h0, 32'h5A5A_03A4, 1'b0);  // Cold miss
        add_row(OP_LOAD,  32'h3A4, SIZE_WORD, 32'h0, 4'h0, 32'h5A5A_03A4, 1'b1);
        add_row(OP_LOAD,  32'h3A4, SIZE_BYTE, 32'h0, 4'h0, 32'h0000_00A4, 1'b1);
        add_row(OP_LOAD,  32'h3A5, SIZE_BYTE, 32'h0, 4'h0, 32'h0000_0003, 1'b1);
        add_row(OP_LOAD,  32'h3A6, SIZE_BYTE, 32'h0, 4'h0, 32'h0000_005A, 1'b1);
        add_row(OP_LOAD,  32'h3A7, SIZE_BYTE, 32'h0, 4'h0, 32'h0000_005A, 1'b1);
        add_row(OP_LOAD,  32'h3A4, SIZE_HALF, 32'h0, 4'h0, 32'h0000_03A4, 1'b1);
        add_row(OP_LOAD,  32'h3A6, SIZE_HALF, 32'h0, 4'h0, 32'h0000_5A5A, 1'b1);
        // Store hits, two with generated strobes and one explicit
        add_row(OP_STORE, 32'h3A5, SIZE_BYTE, 32'h1122_C344, 4'h0, 32'h0, 1'b1);
        add_row(OP_STORE, 32'h3AA, SIZE_HALF, 32'hBEEF_0000, 4'h0, 32'h0, 1'b1);
        add_row(OP_STORE, 32'h3AC, SIZE_WORD, 32'hD1E2_F3C4, 4'h9, 32'h0, 1'b1);
        add_row(OP_LOAD,  32'h3A4, SIZE_WORD, 32'h0, 4'h0, 32'h5A5A_C3A4, 1'b1);
        add_row(OP_LOAD,  32'h3A5, SIZE_BYTE, 32'h0, 4'h0, 32'h0000_00C3, 1'b1);
        add_row(OP_LOAD,  32'h3A8, SIZE_WORD, 32'h0, 4'h0, 32'hBEEF_03A8, 1'b1);
        add_row(OP_LOAD,  32'h3AC, SIZE_WORD, 32'h0, 4'h0, 32'hD15A_03C4, 1'b1);
        // Same index, other tag, dirty eviction
        add_row(OP_LOAD,  32'h0A0, SIZE_WORD, 32'h0, 4'h0, 32'h5A5A_00A0, 1'b0);
        add_row(OP_LOAD,  32'h3A4, SIZE_WORD, 32'h0, 4'h0, 32'h5A5A_C3A4, 1'b0);
        add_row(OP_LOAD,  32'h3AC, SIZE_WORD, 32'h0, 4'h0, 32'hD15A_03C4, 1'b1);
        // Store miss allocates
        add_row(OP_STORE, 32'h1C8, SIZE_WORD, 32'hCAFE_F00D, 4'h0, 32'h0, 1'b0);
        add_row(OP_LOAD,  32'h1C8, SIZE_WORD, 32'h0, 4'h0, 32'hCAFE_F00D, 1'b1);
        add_row(OP_LOAD,  32'h1C4, SIZE_WORD, 32'h0, 4'h0, 32'h5A5A_01C4, 1'b1);
        add_row(OP_STORE, 32'h3A0, SIZE_WORD, 32'h0BAD_BEEF, 4'h0, 32'h0, 1'b1);
        add_row(OP_LOAD,  32'h050, SIZE_WORD, 32'h0, 4'h0, 32'h5A5A_0050, 1'b0);  // Stays clean
        add_row(OP_FLUSH, 32'h0,   SIZE_WORD, 32'h0, 4'h0, 32'h0, 1'b0);
        add_row(OP_LOAD,  32'h1C8, SIZE_WORD, 32'h0, 4'h0, 32'hCAFE_F00D, 1'b0);
        add_row(OP_LOAD,  32'h3A0, SIZE_WORD, 32'h0, 4'h0, 32'h0BAD_BEEF, 1'b0);
        add_row(OP_LOAD,  32'h3A8, SIZE_WORD, 32'h0, 4'h0, 32'hBEEF_03A8, 1'b1);
        add_row(OP_LOAD,  32'h054, SIZE_WORD, 32'h0, 4'h0, 32'h5A5A_0054, 1'b1);
        add_row(OP_LOAD,  32'h0F0, SIZE_WORD, 32'h0, 4'h0, 32'h5A5A_00F0, 1'b0);
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic run_access(input int r);
        row_t  row;
        logic  seen_hit;
        logic  seen_rvalid;
        word_t seen_rdata;
        row = rows[r];
        @(posedge clk);
        #(DRIVE_DELAY);
        cpu_req   = 1'b1;
        cpu_wr    = (row.op == OP_STORE);
        cpu_addr  = row.addr;
        cpu_size  = row.size;
        cpu_wdata = row.wdata;
        cpu_wstrb = row.wstrb;
        @(negedge clk);
        while (!cpu_ready) @(negedge clk);
        seen_hit    = hit;          // Accept cycle
        seen_rvalid = cpu_rvalid;
        seen_rdata  = cpu_rdata;
        @(posedge clk);
        #(DRIVE_DELAY);
        cpu_req = 1'b0;
        cpu_wr  = 1'b0;
        check_value($sformatf("row %0d hit", r), seen_hit, row.exp_hit);
        if (row.op == OP_LOAD) begin
            while (!seen_rvalid) begin
                @(negedge clk);
                seen_rvalid = cpu_rvalid;
                seen_rdata  = cpu_rdata;
            end
            check_value($sformatf("row %0d rdata", r), seen_rdata, row.exp_rdata);
        end else begin
            check_value($sformatf("row %0d rvalid on store", r), seen_rvalid, 1'b0);
            @(negedge clk);
            while (!cpu_ready) @(negedge clk);
        end
    endtask

    task automatic run_flush(input int r);
        @(posedge clk);
        #(DRIVE_DELAY);
        finish = 1'b1;
        @(negedge clk);
        while (!done) @(negedge clk);
        @(posedge clk);
        #(DRIVE_DELAY);
        finish = 1'b0;
        @(negedge clk);
        while (!cpu_ready) @(negedge clk);
        check_value($sformatf("row %0d done after release", r), done, 1'b0);
    endtask

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        cpu_req   = 1'b0;
        cpu_wr    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        cpu_size  = SIZE_WORD;
        finish    = 1'b0;
        fill_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rstn = 1'b1;
        @(negedge clk);
        check_value("cpu_ready after reset", cpu_ready, 1'b1);
        check_value("done after reset", done, 1'b0);
        for (int r = 0; r < rows.size(); r++) begin
            if (rows[r].op == OP_FLUSH) begin
                run_flush(r);
            end else begin
                run_access(r);
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        longint limit_ns;
        wait (table_ready);
        limit_ns = longint'(RESET_CYCLES + rows.size() * ROW_CYCLES) * CLK_PERIOD;
        #(limit_ns);
        errors++;
        $display("Timeout: the tests did not finish within %0d ns", limit_ns);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- hdl/cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem import cache_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  cpu_req,
    input  logic  cpu_wr,
    input  addr_t cpu_addr,
    input  word_t cpu_wdata,
    input  strb_t cpu_wstrb,
    input  size_t cpu_size,
    output logic  cpu_ready,
    output word_t cpu_rdata,
    output logic  cpu_rvalid,
    output logic  hit,
    input  logic  finish,
    output logic  done
);

    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    line_t mem_wdata;
    logic  mem_gnt;
    logic  mem_rvalid;
    line_t mem_rdata;
    logic  write_done;

    data_cache data_cache_i (
        .clk        (clk),
        .rstn       (rstn),
        .cpu_req    (cpu_req),
        .cpu_wr     (cpu_wr),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_wstrb  (cpu_wstrb),
        .cpu_size   (cpu_size),
        .cpu_ready  (cpu_ready),
        .cpu_rdata  (cpu_rdata),
        .cpu_rvalid (cpu_rvalid),
        .hit        (hit),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_gnt    (mem_gnt),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .write_done (write_done),
        .finish     (finish),
        .done       (done)
    );

    line_memory line_memory_i (
        .clk        (clk),
        .rstn       (rstn),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_gnt    (mem_gnt),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .write_done (write_done)
    );

endmodule

//--- hdl/line_memory.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module line_memory import cache_pkg::*; #(
    parameter int READ_LATENCY = `MEM_READ_LATENCY
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  mem_req,
    input  logic  mem_we,
    input  addr_t mem_addr,
    input  line_t mem_wdata,
    output logic  mem_gnt,
    output logic  mem_rvalid,
    output line_t mem_rdata,
    output logic  write_done
);

    localparam int OFFSET_BITS = $clog2(`CACHE_LINE_BYTES);
    localparam int IDX_BITS    = $clog2(`MEM_LINES);
    localparam int CNT_BITS    = $clog2(READ_LATENCY + 1);

    line_t               mem_array [`MEM_LINES];
    logic [IDX_BITS-1:0] req_idx;
    logic [IDX_BITS-1:0] rd_idx;
    logic [CNT_BITS-1:0] rd_cnt;
    logic                rd_busy;

    initial begin
        for (int l = 0; l < `MEM_LINES; l++) begin
            for (int w = 0; w < `CACHE_LINE_BYTES / 4; w++) begin
                mem_array[l][w*32 +: 32] = word_t'(l * `CACHE_LINE_BYTES + w * 4) ^ 32'h5A5A_0000;
            end
        end
    end

    assign req_idx    = mem_addr[OFFSET_BITS +: IDX_BITS];  // Wraps modulo depth
    assign mem_rvalid = rd_busy && (rd_cnt == '0);
    assign mem_rdata  = mem_array[rd_idx];
    assign write_done = !(mem_req && mem_we && !mem_gnt);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_gnt <= 1'b0;
            rd_busy <= 1'b0;
            rd_cnt  <= '0;
            rd_idx  <= '0;
        end else begin
            mem_gnt <= mem_req && !mem_gnt && !rd_busy;
            if (mem_gnt && !mem_we) begin
                rd_busy <= 1'b1;
                rd_cnt  <= CNT_BITS'(READ_LATENCY - 1);
                rd_idx  <= req_idx;
            end else if (mem_rvalid) begin
                rd_busy <= 1'b0;
            end else if (rd_busy) begin
                rd_cnt <= rd_cnt - 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (mem_gnt && mem_we) begin
            mem_array[req_idx] <= mem_wdata;
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (!rstn)
        (mem_req && !mem_gnt) |=> mem_req)
        else $error("line_memory: request dropped before grant");

endmodule

//--- hdl/data_cache.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module data_cache import cache_pkg::*; #(
    parameter int N_LINES = `CACHE_N_LINES
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  cpu_req,
    input  logic  cpu_wr,
    input  addr_t cpu_addr,
    input  word_t cpu_wdata,
    input  strb_t cpu_wstrb,
    input  size_t cpu_size,
    output logic  cpu_ready,
    output word_t cpu_rdata,
    output logic  cpu_rvalid,
    output logic  hit,
    output logic  mem_req,
    output logic  mem_we,
    output addr_t mem_addr,
    output line_t mem_wdata,
    input  logic  mem_gnt,
    input  logic  mem_rvalid,
    input  line_t mem_rdata,
    input  logic  write_done,
    input  logic  finish,
    output logic  done
);

    localparam int OFFSET_BITS = $clog2(`CACHE_LINE_BYTES);
    localparam int IDX_BITS    = $clog2(N_LINES);
    localparam int TAG_BITS    = `CACHE_ADDR_WIDTH - OFFSET_BITS - IDX_BITS;
    localparam logic [IDX_BITS:0] FLUSH_END = (IDX_BITS+1)'(N_LINES);

    logic [TAG_BITS-1:0] tag_array   [N_LINES];
    logic                valid_array [N_LINES];
    logic                dirty_array [N_LINES];
    line_t               data_array  [N_LINES];

    cache_state_t      state;
    logic [IDX_BITS:0] flush_idx;  // One extra bit to mark the end
    logic              req_granted;

    logic  pend_wr;
    addr_t pend_addr;
    word_t pend_wdata;
    strb_t pend_wstrb;
    size_t pend_size;

    logic [IDX_BITS-1:0] curr_idx;
    logic [IDX_BITS-1:0] pend_idx;
    logic [IDX_BITS-1:0] fl_idx;
    logic [TAG_BITS-1:0] curr_tag;
    logic [TAG_BITS-1:0] pend_tag;
    logic                accept;
    logic                miss;
    logic                store_hit;
    logic                load_hit;
    logic                victim_dirty;
    logic                refill_done;
    word_t               curr_rdata;
    word_t               pend_rdata;
    line_t               curr_line;
    line_t               pend_line;

    function automatic addr_t victim_addr(input logic [IDX_BITS-1:0] idx);
        return {tag_array[idx], idx, {OFFSET_BITS{1'b0}}};
    endfunction

    assign curr_idx = cpu_addr[OFFSET_BITS +: IDX_BITS];
    assign curr_tag = cpu_addr[`CACHE_ADDR_WIDTH-1 -: TAG_BITS];
    assign pend_idx = pend_addr[OFFSET_BITS +: IDX_BITS];
    assign pend_tag = pend_addr[`CACHE_ADDR_WIDTH-1 -: TAG_BITS];
    assign fl_idx   = flush_idx[IDX_BITS-1:0];

    assign hit          = valid_array[curr_idx] && (tag_array[curr_idx] == curr_tag);
    assign cpu_ready    = (state == IDLE);
    assign accept       = cpu_req && cpu_ready;
    assign miss         = accept && !hit;
    assign store_hit    = accept && hit && cpu_wr;
    assign load_hit     = accept && hit && !cpu_wr;
    assign victim_dirty = valid_array[curr_idx] && dirty_array[curr_idx];
    assign refill_done  = (state == REFILL) && mem_rvalid;

    line_access curr_access (
        .line_in  (data_array[curr_idx]),
        .offset   (cpu_addr[OFFSET_BITS-1:0]),
        .size     (cpu_size),
        .wdata    (cpu_wdata),
        .wstrb    (cpu_wstrb),
        .rdata    (curr_rdata),
        .line_out (curr_line)
    );

    line_access pend_access (
        .line_in  (mem_rdata),
        .offset   (pend_addr[OFFSET_BITS-1:0]),
        .size     (pend_size),
        .wdata    (pend_wdata),
        .wstrb    (pend_wstrb),
        .rdata    (pend_rdata),
        .line_out (pend_line)
    );

    // Load miss data goes straight through in the refill cycle
    assign cpu_rvalid = load_hit || (refill_done && !pend_wr);
    assign cpu_rdata  = load_hit ? curr_rdata : pend_rdata;

    always_comb begin
        mem_req   = 1'b0;
        mem_we    = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        case (state)
            IDLE: begin
                if (miss) begin
                    mem_req = 1'b1;
                    if (victim_dirty) begin
                        mem_we    = 1'b1;
                        mem_addr  = victim_addr(curr_idx);
                        mem_wdata = data_array[curr_idx];
                    end else begin
                        mem_addr = {cpu_addr[`CACHE_ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
                    end
                end
            end
            WRITEBACK: begin
                mem_req   = 1'b1;
                mem_we    = 1'b1;
                mem_addr  = victim_addr(pend_idx);
                mem_wdata = data_array[pend_idx];
            end
            REFILL: begin
                mem_req  = !req_granted;  // Held through the grant cycle
                mem_addr = {pend_addr[`CACHE_ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            end
            FLUSH_WB: begin
                mem_req   = 1'b1;
                mem_we    = 1'b1;
                mem_addr  = victim_addr(fl_idx);
                mem_wdata = data_array[fl_idx];
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= IDLE;
            flush_idx   <= '0;
            req_granted <= 1'b0;
            done        <= 1'b0;
            for (int i = 0; i < N_LINES; i++) begin
                valid_array[i] <= 1'b0;
                dirty_array[i] <= 1'b0;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (store_hit) begin
                        dirty_array[curr_idx] <= 1'b1;
                    end
                    if (miss) begin
                        req_granted <= 1'b0;
                        state       <= victim_dirty ? WRITEBACK : REFILL;
                    end else if (finish) begin
                        flush_idx <= '0;
                        state     <= FLUSH;
                    end
                end
                WRITEBACK: begin
                    if (mem_gnt) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (mem_gnt) begin
                        req_granted <= 1'b1;
                    end
                    if (mem_rvalid) begin
                        valid_array[pend_idx] <= 1'b1;
                        dirty_array[pend_idx] <= pend_wr;  // Merged store makes it dirty
                        state                 <= IDLE;
                    end
                end
                FLUSH: begin
                    if (flush_idx == FLUSH_END) begin
                        if (write_done) begin
                            done  <= 1'b1;
                            state <= FLUSH_DONE;
                        end
                    end else if (valid_array[fl_idx] && dirty_array[fl_idx]) begin
                        state <= FLUSH_WB;
                    end else begin
                        flush_idx <= flush_idx + 1'b1;  // Skip clean line
                    end
                end
                FLUSH_WB: begin
                    if (mem_gnt) begin
                        valid_array[fl_idx] <= 1'b0;
                        dirty_array[fl_idx] <= 1'b0;
                        flush_idx           <= flush_idx + 1'b1;
                        state               <= FLUSH;
                    end
                end
                FLUSH_DONE: begin
                    if (!finish) begin
                        done  <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (store_hit) begin
            data_array[curr_idx] <= curr_line;
        end
        if (miss) begin
            pend_wr    <= cpu_wr;
            pend_addr  <= cpu_addr;
            pend_wdata <= cpu_wdata;
            pend_wstrb <= cpu_wstrb;
            pend_size  <= cpu_size;
        end
        if (refill_done) begin
            tag_array[pend_idx]  <= pend_tag;
            data_array[pend_idx] <= pend_wr ? pend_line : mem_rdata;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
        (mem_req && !mem_gnt) |=>
            (mem_req && $stable(mem_we) && $stable(mem_addr) && $stable(mem_wdata)))
        else $error("data_cache: memory request changed before its grant");

    a_rvalid_in_refill: assert property (@(posedge clk) disable iff (!rstn)
        mem_rvalid |-> (state == REFILL && req_granted))
        else $error("data_cache: read data without a granted refill");

endmodule

//--- hdl/line_access.sv
`timescale 1ns/1ps

module line_access import cache_pkg::*; (
    input  line_t      line_in,
    input  logic [3:0] offset,
    input  size_t      size,
    input  word_t      wdata,
    input  strb_t      wstrb,
    output word_t      rdata,
    output line_t      line_out
);

    logic [1:0] word_sel;
    logic [1:0] byte_sel;
    word_t      sel_word;
    strb_t      gen_strb;
    strb_t      strb;

    assign word_sel = offset[3:2];
    assign byte_sel = offset[1:0];
    assign sel_word = line_in[word_sel*32 +: 32];

    always_comb begin
        case (size)
            SIZE_BYTE: rdata = {24'h0, sel_word[byte_sel*8 +: 8]};
            SIZE_HALF: rdata = {16'h0, sel_word[byte_sel[1]*16 +: 16]};
            default:   rdata = sel_word;
        endcase
    end

    always_comb begin
        case (size)
            SIZE_BYTE: gen_strb = 4'b0001 << byte_sel;
            SIZE_HALF: gen_strb = byte_sel[1] ? 4'b1100 : 4'b0011;
            default:   gen_strb = 4'b1111;
        endcase
    end

    assign strb = (wstrb != 4'b0000) ? wstrb : gen_strb;  // CPU strobe wins

    // Store data is lane aligned so byte b of wdata lands in byte b of the word
    always_comb begin
        line_out = line_in;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                line_out[word_sel*32 + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

    always_comb begin
        assert (size !== 2'b11)
            else $error("line_access: reserved size code 3");
    end

endmodule

//--- hdl/cache_pkg.sv
package cache_pkg;

    typedef logic [31:0]  addr_t;  // Byte address
    typedef logic [31:0]  word_t;
    typedef logic [3:0]   strb_t;
    typedef logic [127:0] line_t;  // Four words
    typedef logic [1:0]   size_t;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    typedef enum logic [2:0] {
        IDLE,        // Serving hits, accepting requests
        WRITEBACK,   // Dirty victim out to memory
        REFILL,      // Waiting for line data
        FLUSH,       // Pick next line to clean
        FLUSH_WB,
        FLUSH_DONE   // Hold done until finish drops
    } cache_state_t;

endpackage

//--- hdl/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Cache geometry
`define CACHE_ADDR_WIDTH 32
`define CACHE_LINE_BYTES 16
`define CACHE_N_LINES    4

// Backing store
`define MEM_LINES        64
`define MEM_READ_LATENCY 3

`endif
